// ==== Bender.yml ====
package:
  name: acpo

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/acpo_pkg.sv
      - verilog/act_lane.sv
      - verilog/pool_lane.sv
      - verilog/acpo_top.sv
      - target: test
        files:
          - bench/acpo_tb.sv

// ==== bench/acpo_tb.sv ====
/* testbench for the activation and pooling stage, applying a stimulus table to acpo_top.
   a behavioral model queues the expected fc and pooled beats and a negedge monitor compares them. */

`default_nettype none

`include "acpo_cfg.svh"

module acpo_tb;

    localparam int rng_seed    = 67;
    localparam int rand_rows   = 240;
    localparam int drain_limit = 64; // cycles allowed for the queues to empty.

    // one stimulus row; fc_exp is the expected fc result for that row.
    typedef struct packed {
        logic       valid;
        logic       last;
        logic [7:0] data;
        logic [9:0] addr;
        logic [7:0] fc_exp;
    } row_t;

    // one expected output beat and the monitor cycle in which it is due.
    typedef struct packed {
        int         due;
        int         lane;
        logic       last;
        logic [7:0] data;
        logic [9:0] addr;
    } exp_t;

    logic clk = 1'b0;
    logic reset_i;

    acpo_pkg::lane_beat_t conv_acc [`ACPO_ACC_NUM];
    acpo_pkg::fc_beat_t   fc_acc;
    acpo_pkg::fc_beat_t   fc_act;
    acpo_pkg::lane_beat_t pool [`ACPO_ACC_NUM];

    row_t rows [$];
    exp_t fc_q [$];
    exp_t pool_q [$];

    int win_cnt [`ACPO_ACC_NUM]; // model window count per lane.
    logic [7:0] win_max [`ACPO_ACC_NUM];

    int cyc    = 0;
    int checks = 0;
    int errors = 0;

    acpo_top acpo_top_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .conv_acc_i (conv_acc),
        .fc_acc_i   (fc_acc),
        .fc_act_o   (fc_act),
        .pool_o     (pool)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1; // counts rising edges, read by the driver before it moves.
    end

    function automatic logic [7:0] relu(input logic [7:0] x);
        return x[7] ? 8'h00 : x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %0h, expected %0h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic add_row(input logic v, input logic l, input logic [7:0] d,
                           input logic [9:0] a, input logic [7:0] fc_exp);
        row_t r;
        r = '{valid: v, last: l, data: d, addr: a, fc_exp: fc_exp};
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [7:0]  d;
        logic [7:0]  fd;
        logic        v;
        logic        l;
        // idle rows right after reset.
        for (int i = 0; i < 4; i++) begin
            add_row(1'b0, 1'b0, 8'h00, 10'h000, 8'h00);
        end
        // a full window of four, with the fc lane seeing the negated data.
        add_row(1'b1, 1'b0, 8'h05, 10'h000, 8'h00);
        add_row(1'b1, 1'b0, 8'hf6, 10'h001, 8'h0a);
        add_row(1'b1, 1'b0, 8'h14, 10'h002, 8'h00);
        add_row(1'b1, 1'b0, 8'he2, 10'h003, 8'h1e);
        // short window closed early by last.
        add_row(1'b1, 1'b0, 8'h30, 10'h004, 8'h00);
        add_row(1'b1, 1'b1, 8'h10, 10'h005, 8'h00);
        // idle rows with junk data inside a window.
        add_row(1'b1, 1'b0, 8'hc0, 10'h008, 8'h40);
        add_row(1'b0, 1'b0, 8'h7f, 10'h3ff, 8'h00);
        add_row(1'b1, 1'b0, 8'h22, 10'h009, 8'h00);
        add_row(1'b0, 1'b0, 8'h7e, 10'h3fe, 8'h00);
        add_row(1'b1, 1'b0, 8'h81, 10'h00a, 8'h7f);
        add_row(1'b1, 1'b0, 8'h80, 10'h00b, 8'h00);
        add_row(1'b1, 1'b1, 8'hff, 10'h00c, 8'h01); // single beat window.
        add_row(1'b0, 1'b0, 8'h00, 10'h000, 8'h00);
        // random section, roughly three valid rows in four.
        for (int i = 0; i < rand_rows; i++) begin
            r  = $urandom;
            v  = (r[1:0] != 2'b00);
            l  = v && (r[7:4] == 4'h0);
            d  = r[15:8];
            fd = -d;
            add_row(v, l, d, r[25:16], v ? relu(fd) : 8'h00);
        end
        for (int i = 0; i < 4; i++) begin
            add_row(1'b0, 1'b0, 8'h00, 10'h000, 8'h00);
        end
    endtask

    task automatic drive_row(input row_t row);
        acpo_pkg::lane_beat_t b;
        acpo_pkg::fc_beat_t   fb;
        int                   off;
        for (int k = 0; k < `ACPO_ACC_NUM; k++) begin
            off     = 9 * k;
            b.valid = row.valid;
            b.last  = row.last;
            b.data  = row.data + off[7:0]; // wraps to 8 bits.
            b.addr  = row.addr + k[9:0];
            conv_acc[k] <= b;
        end
        fb.valid = row.valid;
        fb.last  = row.last;
        fb.data  = -row.data;
        fc_acc <= fb;
    endtask

    // fc beats are due two monitor cycles after the drive edge, pooled beats three.
    task automatic predict_row(input row_t row);
        exp_t       e;
        logic [7:0] d;
        logic [7:0] r;
        logic [9:0] a;
        int         off;
        if (row.valid) begin
            e = '{due: cyc + 2, lane: 0, last: row.last, data: row.fc_exp, addr: '0};
            fc_q.push_back(e);
            for (int k = 0; k < `ACPO_ACC_NUM; k++) begin
                off = 9 * k;
                d   = row.data + off[7:0];
                r   = relu(d);
                if (win_cnt[k] == 0 || r > win_max[k]) begin
                    win_max[k] = r;
                end
                win_cnt[k]++;
                if (row.last || win_cnt[k] == `ACPO_POOL_WIN) begin
                    a = row.addr + k[9:0];
                    e = '{due: cyc + 3, lane: k, last: row.last, data: win_max[k],
                          addr: a >> `ACPO_POOL_SHIFT};
                    pool_q.push_back(e);
                    win_cnt[k] = 0;
                end
            end
        end
    endtask

    task automatic check_fc();
        exp_t e;
        if (fc_q.size() > 0 && fc_q[0].due <= cyc) begin
            e = fc_q.pop_front();
            check_value("fc_act_o.valid", fc_act.valid, 1);
            check_value("fc_act_o.last", fc_act.last, e.last);
            check_value("fc_act_o.data", fc_act.data, e.data);
        end else begin
            check_value("fc_act_o.valid", fc_act.valid, 0);
            check_value("fc_act_o.last", fc_act.last, 0);
        end
    endtask

    task automatic check_pool();
        exp_t e;
        exp_t want [`ACPO_ACC_NUM];
        logic hit  [`ACPO_ACC_NUM];
        for (int k = 0; k < `ACPO_ACC_NUM; k++) begin
            hit[k] = 1'b0;
        end
        while (pool_q.size() > 0 && pool_q[0].due <= cyc) begin
            e = pool_q.pop_front();
            hit[e.lane]  = 1'b1;
            want[e.lane] = e;
        end
        for (int k = 0; k < `ACPO_ACC_NUM; k++) begin
            if (hit[k]) begin
                check_value($sformatf("pool_o[%0d].valid", k), pool[k].valid, 1);
                check_value($sformatf("pool_o[%0d].last", k), pool[k].last, want[k].last);
                check_value($sformatf("pool_o[%0d].data", k), pool[k].data, want[k].data);
                check_value($sformatf("pool_o[%0d].addr", k), pool[k].addr, want[k].addr);
            end else begin
                check_value($sformatf("pool_o[%0d].valid", k), pool[k].valid, 0);
                check_value($sformatf("pool_o[%0d].last", k), pool[k].last, 0);
            end
        end
    endtask

    // outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (reset_i === 1'b0) begin
            check_fc();
            check_pool();
        end
    end

    initial begin
        logic [31:0] seed_ret;
        int          t;
        reset_i = 1'b1;
        fc_acc  = '0;
        for (int k = 0; k < `ACPO_ACC_NUM; k++) begin
            conv_acc[k] = '0;
            win_cnt[k]  = 0;
            win_max[k]  = 8'h00;
        end
        seed_ret = $urandom(rng_seed);
        build_table();

        repeat (5) @(posedge clk);
        reset_i <= 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            drive_row(rows[i]);
            predict_row(rows[i]);
        end

        t = 0;
        while ((fc_q.size() > 0 || pool_q.size() > 0) && t < drain_limit) begin
            @(posedge clk);
            t++;
        end
        if (fc_q.size() > 0 || pool_q.size() > 0) begin
            errors++;
            $display("timeout: expected outputs never arrived, %0d fc and %0d pooled beats left",
                     fc_q.size(), pool_q.size());
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
verilog/acpo_pkg.sv
verilog/act_lane.sv
verilog/pool_lane.sv
verilog/acpo_top.sv
bench/acpo_tb.sv

// ==== verilog/acpo_cfg.svh ====
/* sizing constants for the activation and pooling stage.
   include before the package and any module that sizes ports or counters. */

`ifndef ACPO_CFG_SVH
`define ACPO_CFG_SVH

// lane counts.
`define ACPO_ACC_NUM     16 // convolution accumulator lanes.

// datapath widths.
`define ACPO_DATA_WIDTH  8  // signed accumulator and activation data.
`define ACPO_ADDR_WIDTH  10 // feature map address carried with each conv beat.

// pooling window.
// the upstream sends each 2x2 window as consecutive beats in flattened order,
// so the window is simply a run of beats on one lane.
`define ACPO_POOL_WIN    4  // valid beats that make one full window.
`define ACPO_POOL_SHIFT  2  // log2 of the window, used to scale the address.

`endif

// ==== verilog/acpo_pkg.sv ====
/* beat formats shared by the activation lanes, the pooling lanes and the top level.
   modules reference the types by scoped name. */

`default_nettype none

`include "acpo_cfg.svh"

package acpo_pkg;

    // signed data word as produced by the accumulators.
    typedef logic signed [`ACPO_DATA_WIDTH-1:0] data_t;

    // feature map address of a convolution beat.
    typedef logic [`ACPO_ADDR_WIDTH-1:0] addr_t;

    // one beat on a convolution lane.
    typedef struct packed {
        logic  valid; // beat carries data this cycle.
        logic  last;  // final beat of the feature map.
        data_t data;
        addr_t addr;
    } lane_beat_t;

    // one beat on the fully connected lane, which has no address.
    typedef struct packed {
        logic  valid;
        logic  last;
        data_t data;
    } fc_beat_t;

endpackage

`default_nettype wire

// ==== verilog/acpo_top.sv ====
/* post accumulation stage with relu on all seventeen lanes and max pooling on the conv lanes.
   the fully connected lane leaves after activation without pooling. */

`default_nettype none

`include "acpo_cfg.svh"

module acpo_top (
    input  logic                 clk,
    input  logic                 reset_i,

    input  acpo_pkg::lane_beat_t conv_acc_i [`ACPO_ACC_NUM], // one beat per conv accumulator.
    input  acpo_pkg::fc_beat_t   fc_acc_i,

    output acpo_pkg::fc_beat_t   fc_act_o,                   // activated fc result.
    output acpo_pkg::lane_beat_t pool_o     [`ACPO_ACC_NUM]  // pooled conv results.
);

    // activated conv beats between the relu stage and the pooling stage.
    acpo_pkg::lane_beat_t conv_act [`ACPO_ACC_NUM];

    // each conv lane is a relu register followed by its own pooling lane.
    // lanes share nothing, so they pool independently.
    for (genvar k = 0; k < `ACPO_ACC_NUM; k++) begin : g_conv

        act_lane #(
            .beat_t  (acpo_pkg::lane_beat_t)
        ) u_act (
            .clk     (clk),
            .reset_i (reset_i),
            .beat_i  (conv_acc_i[k]),
            .beat_o  (conv_act[k])
        );

        pool_lane u_pool (
            .clk     (clk),
            .reset_i (reset_i),
            .beat_i  (conv_act[k]),
            .beat_o  (pool_o[k])
        );

    end

    // the fc lane is split off here and has one cycle of latency in total.
    act_lane #(
        .beat_t  (acpo_pkg::fc_beat_t)
    ) u_fc_act (
        .clk     (clk),
        .reset_i (reset_i),
        .beat_i  (fc_acc_i),
        .beat_o  (fc_act_o)
    );

endmodule

`default_nettype wire

// ==== verilog/act_lane.sv ====
/* registered relu for one lane, generic over the beat format.
   used for the sixteen convolution lanes and for the fully connected lane. */

`default_nettype none

module act_lane #(
    parameter type beat_t = acpo_pkg::lane_beat_t
) (
    input  logic  clk,
    input  logic  reset_i,
    input  beat_t beat_i,
    output beat_t beat_o
);

    beat_t beat_q;
    logic  is_neg;

    assign is_neg = beat_i.data < 0; // data field is signed in every beat format.

    // every field is copied straight through the register.
    // only data is touched, and only when it is negative.
    always_ff @(posedge clk) begin
        beat_q <= beat_i;
        if (is_neg) begin
            beat_q.data <= '0;
        end
        if (reset_i) begin
            beat_q.valid <= 1'b0;
            beat_q.last  <= 1'b0;
        end
    end

    assign beat_o = beat_q;

    // a valid output never carries a negative value.
    relu_nonneg_a: assert property (
        @(posedge clk) disable iff (reset_i)
        beat_o.valid |-> (beat_o.data >= 0)
    );

endmodule

`default_nettype wire

// ==== verilog/pool_lane.sv ====
/* max pooling over runs of consecutive activated beats on one convolution lane.
   a window closes on its fourth valid beat or on a last beat, whichever comes first. */

`default_nettype none

`include "acpo_cfg.svh"

module pool_lane (
    input  logic                 clk,
    input  logic                 reset_i,
    input  acpo_pkg::lane_beat_t beat_i,
    output acpo_pkg::lane_beat_t beat_o
);

    logic [`ACPO_POOL_SHIFT:0] cnt_q;   // valid beats already folded into the open window.
    acpo_pkg::data_t           max_q;   // running maximum of the open window.
    acpo_pkg::data_t           win_max; // maximum including the current beat.
    logic                      closing;

    logic                      valid_q;
    logic                      last_q;
    acpo_pkg::data_t           data_q;
    acpo_pkg::addr_t           addr_q;

    // the window ends on its final slot or early on the end of the feature map.
    assign closing = beat_i.valid && (beat_i.last || (cnt_q == (`ACPO_POOL_WIN - 1)));

    // the first beat of a window always loads, so a stale maximum never leaks in.
    assign win_max = ((cnt_q == '0) || (beat_i.data > max_q)) ? beat_i.data : max_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q   <= '0;
            max_q   <= '0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= closing;
            last_q  <= closing && beat_i.last;
            if (beat_i.valid) begin
                max_q <= win_max; // ignored after a close since the count restarts.
                if (closing) begin
                    cnt_q <= '0;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    // pooled result and its address are only loaded when a window closes.
    always_ff @(posedge clk) begin
        if (closing) begin
            data_q <= win_max;
            addr_q <= beat_i.addr >> `ACPO_POOL_SHIFT; // one address per window.
        end
    end

    assign beat_o = '{valid: valid_q, last: last_q, data: data_q, addr: addr_q};

    // the activation lane must never raise last on an idle cycle.
    last_has_valid_a: assert property (
        @(posedge clk) disable iff (reset_i)
        beat_i.last |-> beat_i.valid
    );

    // the window count stays within one pooling window.
    cnt_in_range_a: assert property (
        @(posedge clk) disable iff (reset_i)
        cnt_q <= `ACPO_POOL_WIN
    );

endmodule

`default_nettype wire
